// File: common/csr_pkg.sv
// CSR bus address map, operation encoding and data types shared by the arbiter and peripherals
`default_nettype none

package csr_pkg;

  // CSR address and data widths
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // encoding follows the low bits of the RISC-V csrrw/csrrs/csrrc funct3
  typedef enum logic [1:0] {
    csr_read  = 2'b00,
    csr_write = 2'b01,
    csr_set   = 2'b10,
    csr_clear = 2'b11
  } csr_op_t;

  // board pin counts
  localparam int unsigned LedWidth = 4;
  localparam int unsigned BtnWidth = 4;

  typedef logic [LedWidth-1:0] led_t;
  typedef logic [BtnWidth-1:0] btn_t;

  // peripheral register map
  localparam csr_addr_t LedAddr    = 12'h7c0;
  localparam csr_addr_t BtnAddr    = 12'h7c1;
  localparam csr_addr_t TxDataAddr = 12'h7c2;
  localparam csr_addr_t TxStatAddr = 12'h7c3;

  // new register value for a csr operation
  function automatic csr_data_t csr_apply(csr_op_t op, csr_data_t old_val, csr_data_t wdata);
    csr_data_t new_val;
    case (op)
      csr_write: new_val = wdata;
      csr_set:   new_val = old_val | wdata;
      csr_clear: new_val = old_val & ~wdata;
      default:   new_val = old_val;
    endcase
    return new_val;
  endfunction

endpackage

`default_nettype wire

// File: common/uart_pkg.sv
// UART transmit path types, used by the transmit FIFO and the serializer
`default_nettype none

package uart_pkg;

  // one serial character
  typedef logic [7:0] uart_byte_t;

  // fill level as reported in the status register, bits 7:0
  typedef logic [7:0] uart_count_t;

  // serializer frame phases
  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } uart_state_t;

endpackage

`default_nettype wire

// File: rtl/csr_arbiter.sv
// round-robin arbiter, turns the hart and debug four-phase ports into one-cycle CSR bus accesses
`default_nettype none

module csr_arbiter (
  input  wire logic               clk,
  input  wire logic               arst_n,
  // hart requester
  input  wire logic               hart_req,
  input  csr_pkg::csr_op_t        hart_op,
  input  csr_pkg::csr_addr_t      hart_addr,
  input  csr_pkg::csr_data_t      hart_wdata,
  output logic                    hart_ack,
  output csr_pkg::csr_data_t      hart_rdata,
  // debug requester
  input  wire logic               dbg_req,
  input  csr_pkg::csr_op_t        dbg_op,
  input  csr_pkg::csr_addr_t      dbg_addr,
  input  csr_pkg::csr_data_t      dbg_wdata,
  output logic                    dbg_ack,
  output csr_pkg::csr_data_t      dbg_rdata,
  // peripheral read data, zero when not addressed
  input  csr_pkg::csr_data_t      io_rdata,
  input  csr_pkg::csr_data_t      fifo_rdata,
  // internal CSR bus
  output logic                    bus_valid,
  output csr_pkg::csr_op_t        bus_op,
  output csr_pkg::csr_addr_t      bus_addr,
  output csr_pkg::csr_data_t      bus_wdata
);

  typedef enum logic [1:0] {
    arb_idle,
    arb_access,
    arb_ack
  } arb_state_t;

  arb_state_t         state_q;
  // granted port during an access, last served port while idle
  logic               gnt_dbg_q;
  logic               grant_dbg;
  logic               gnt_req;
  csr_pkg::csr_data_t merged_rdata;

  // dbg wins a tie only if hart was served last
  assign grant_dbg    = dbg_req & (~hart_req | ~gnt_dbg_q);
  assign gnt_req      = gnt_dbg_q ? dbg_req : hart_req;
  assign merged_rdata = io_rdata | fifo_rdata;

  assign bus_valid = (state_q == arb_access);
  assign hart_ack  = (state_q == arb_ack) & ~gnt_dbg_q;
  assign dbg_ack   = (state_q == arb_ack) & gnt_dbg_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= arb_idle;
      // hart goes first after reset
      gnt_dbg_q <= 1'b1;
    end else begin
      case (state_q)
        arb_idle: begin
          if (hart_req || dbg_req) begin
            state_q   <= arb_access;
            gnt_dbg_q <= grant_dbg;
          end
        end
        arb_access: state_q <= arb_ack;
        arb_ack: begin
          // hold ack until the owner drops req
          if (!gnt_req) begin
            state_q <= arb_idle;
          end
        end
        default: state_q <= arb_idle;
      endcase
    end
  end

  // bus fields follow the winner while idle, frozen during the access
  always_ff @(posedge clk) begin
    if (state_q == arb_idle) begin
      bus_op    <= grant_dbg ? dbg_op : hart_op;
      bus_addr  <= grant_dbg ? dbg_addr : hart_addr;
      bus_wdata <= grant_dbg ? dbg_wdata : hart_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == arb_access) begin
      if (gnt_dbg_q) begin
        dbg_rdata <= merged_rdata;
      end else begin
        hart_rdata <= merged_rdata;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/csr_io.sv
// LED and button CSRs, the LED register takes all four operations and the buttons are read-only
`default_nettype none

module csr_io (
  input  wire logic          clk,
  input  wire logic          arst_n,
  input  wire logic          bus_valid,
  input  csr_pkg::csr_op_t   bus_op,
  input  csr_pkg::csr_addr_t bus_addr,
  input  csr_pkg::csr_data_t bus_wdata,
  input  csr_pkg::btn_t      btn,
  output csr_pkg::csr_data_t rdata,
  output csr_pkg::led_t      led
);

  csr_pkg::led_t      led_q;
  csr_pkg::btn_t      btn_meta_q;
  csr_pkg::btn_t      btn_sync_q;
  csr_pkg::csr_data_t led_old;
  csr_pkg::csr_data_t led_new;
  logic               led_hit;

  assign led_hit = bus_valid && (bus_addr == csr_pkg::LedAddr);
  assign led_old = csr_pkg::csr_data_t'(led_q);
  assign led_new = csr_pkg::csr_apply(bus_op, led_old, bus_wdata);
  assign led     = led_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      led_q <= '0;
    end else if (led_hit) begin
      // upper bits have no pins behind them
      led_q <= led_new[csr_pkg::LedWidth-1:0];
    end
  end

  // pins are asynchronous to clk
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      btn_meta_q <= '0;
      btn_sync_q <= '0;
    end else begin
      btn_meta_q <= btn;
      btn_sync_q <= btn_meta_q;
    end
  end

  always_comb begin
    rdata = '0;
    if (bus_valid) begin
      case (bus_addr)
        csr_pkg::LedAddr: rdata = led_old;
        csr_pkg::BtnAddr: rdata = csr_pkg::csr_data_t'(btn_sync_q);
        default:          rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: uart/uart_tx_fifo.sv
// transmit FIFO behind the TX data and status CSRs, hands bytes to the UART serializer
`default_nettype none

module uart_tx_fifo #(
  parameter int unsigned FifoDepth = 4
) (
  input  wire logic             clk,
  input  wire logic             arst_n,
  input  wire logic             bus_valid,
  input  csr_pkg::csr_op_t      bus_op,
  input  csr_pkg::csr_addr_t    bus_addr,
  input  csr_pkg::csr_data_t    bus_wdata,
  input  wire logic             tx_ready,
  output csr_pkg::csr_data_t    rdata,
  output logic                  tx_valid,
  output uart_pkg::uart_byte_t  tx_byte
);

  // FifoDepth is a power of two, at least 2
  localparam int unsigned PtrWidth = $clog2(FifoDepth);
  localparam int unsigned CntWidth = PtrWidth + 1;

  uart_pkg::uart_byte_t mem [FifoDepth];
  logic [PtrWidth-1:0]  wr_ptr_q;
  logic [PtrWidth-1:0]  rd_ptr_q;
  logic [CntWidth-1:0]  count_q;
  logic                 full;
  logic                 empty;
  logic                 push;
  logic                 pop;

  assign full  = (count_q == CntWidth'(FifoDepth));
  assign empty = (count_q == '0);

  // only a plain write pushes, a full FIFO drops it
  assign push = bus_valid && (bus_addr == csr_pkg::TxDataAddr) &&
                (bus_op == csr_pkg::csr_write) && !full;
  assign pop  = tx_valid && tx_ready;

  assign tx_valid = !empty;
  assign tx_byte  = mem[rd_ptr_q];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // pointers wrap on their own
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= bus_wdata[7:0];
    end
  end

  // status: count 7:0, full 8, empty 9; the data register reads zero
  always_comb begin
    rdata = '0;
    if (bus_valid && (bus_addr == csr_pkg::TxStatAddr)) begin
      rdata[7:0] = uart_pkg::uart_count_t'(count_q);
      rdata[8]   = full;
      rdata[9]   = empty;
    end
  end

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
// 8N1 UART serializer, takes one byte per valid/ready handoff and shifts it out LSB first
`default_nettype none

module uart_tx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  wire logic            clk,
  input  wire logic            arst_n,
  input  wire logic            tx_valid,
  input  uart_pkg::uart_byte_t tx_byte,
  output logic                 tx_ready,
  output logic                 tx
);

  localparam int unsigned CntWidth = (ClksPerBit > 1) ? $clog2(ClksPerBit) : 1;

  uart_pkg::uart_state_t state_q;
  logic [CntWidth-1:0]   clk_cnt_q;
  logic [2:0]            bit_idx_q;
  uart_pkg::uart_byte_t  shift_q;
  logic                  bit_done;

  assign bit_done = (clk_cnt_q == CntWidth'(ClksPerBit - 1));
  assign tx_ready = (state_q == uart_pkg::st_idle);

  // line idles high, start low, stop high
  always_comb begin
    case (state_q)
      uart_pkg::st_start: tx = 1'b0;
      uart_pkg::st_data:  tx = shift_q[0];
      default:            tx = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= uart_pkg::st_idle;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
    end else begin
      clk_cnt_q <= bit_done ? '0 : clk_cnt_q + 1'b1;
      case (state_q)
        uart_pkg::st_idle: begin
          clk_cnt_q <= '0;
          if (tx_valid) begin
            state_q <= uart_pkg::st_start;
          end
        end
        uart_pkg::st_start: begin
          if (bit_done) begin
            state_q   <= uart_pkg::st_data;
            bit_idx_q <= '0;
          end
        end
        uart_pkg::st_data: begin
          if (bit_done) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= uart_pkg::st_stop;
            end
          end
        end
        uart_pkg::st_stop: begin
          if (bit_done) begin
            state_q <= uart_pkg::st_idle;
          end
        end
        default: state_q <= uart_pkg::st_idle;
      endcase
    end
  end

  // byte captured at the handoff, shifted at each data bit boundary
  always_ff @(posedge clk) begin
    if (tx_ready && tx_valid) begin
      shift_q <= tx_byte;
    end else if ((state_q == uart_pkg::st_data) && bit_done) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: rtl/csr_subsys_top.sv
// CSR peripheral subsystem top, connects the request arbiter, LED/button CSRs, TX FIFO and UART
`default_nettype none

module csr_subsys_top #(
  parameter int unsigned FifoDepth  = 4,
  parameter int unsigned ClksPerBit = 16
) (
  input  wire logic          clk,
  input  wire logic          arst_n,
  // hart port
  input  wire logic          hart_req,
  input  csr_pkg::csr_op_t   hart_op,
  input  csr_pkg::csr_addr_t hart_addr,
  input  csr_pkg::csr_data_t hart_wdata,
  output logic               hart_ack,
  output csr_pkg::csr_data_t hart_rdata,
  // debug port
  input  wire logic          dbg_req,
  input  csr_pkg::csr_op_t   dbg_op,
  input  csr_pkg::csr_addr_t dbg_addr,
  input  csr_pkg::csr_data_t dbg_wdata,
  output logic               dbg_ack,
  output csr_pkg::csr_data_t dbg_rdata,
  // board pins
  input  csr_pkg::btn_t      btn,
  output csr_pkg::led_t      led,
  output logic               tx
);

  // shared CSR bus
  logic                 bus_valid;
  csr_pkg::csr_op_t     bus_op;
  csr_pkg::csr_addr_t   bus_addr;
  csr_pkg::csr_data_t   bus_wdata;
  csr_pkg::csr_data_t   io_rdata;
  csr_pkg::csr_data_t   fifo_rdata;

  // FIFO to serializer
  logic                 tx_valid;
  logic                 tx_ready;
  uart_pkg::uart_byte_t tx_byte;

  csr_arbiter i_arbiter (
    .clk        (clk),
    .arst_n     (arst_n),
    .hart_req   (hart_req),
    .hart_op    (hart_op),
    .hart_addr  (hart_addr),
    .hart_wdata (hart_wdata),
    .hart_ack   (hart_ack),
    .hart_rdata (hart_rdata),
    .dbg_req    (dbg_req),
    .dbg_op     (dbg_op),
    .dbg_addr   (dbg_addr),
    .dbg_wdata  (dbg_wdata),
    .dbg_ack    (dbg_ack),
    .dbg_rdata  (dbg_rdata),
    .io_rdata   (io_rdata),
    .fifo_rdata (fifo_rdata),
    .bus_valid  (bus_valid),
    .bus_op     (bus_op),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata)
  );

  csr_io i_csr_io (
    .clk       (clk),
    .arst_n    (arst_n),
    .bus_valid (bus_valid),
    .bus_op    (bus_op),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .btn       (btn),
    .rdata     (io_rdata),
    .led       (led)
  );

  uart_tx_fifo #(
    .FifoDepth (FifoDepth)
  ) i_tx_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .bus_valid (bus_valid),
    .bus_op    (bus_op),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .tx_ready  (tx_ready),
    .rdata     (fifo_rdata),
    .tx_valid  (tx_valid),
    .tx_byte   (tx_byte)
  );

  uart_tx #(
    .ClksPerBit (ClksPerBit)
  ) i_uart_tx (
    .clk      (clk),
    .arst_n   (arst_n),
    .tx_valid (tx_valid),
    .tx_byte  (tx_byte),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

endmodule

`default_nettype wire

// File: tests/tb_csr_subsys.sv
// testbench that drives both requester ports of csr_subsys_top and checks CSR reads and the UART line
`default_nettype none

module tb_csr_subsys;

  localparam int FifoDepth   = 4;
  localparam int ClksPerBit  = 16;
  localparam int FrameCycles = 10 * ClksPerBit;
  localparam int AckTimeout  = 50;
  localparam csr_pkg::csr_data_t LedMask = (32'd1 << csr_pkg::LedWidth) - 32'd1;

  logic               clk;
  logic               arst_n;
  logic               hart_req;
  csr_pkg::csr_op_t   hart_op;
  csr_pkg::csr_addr_t hart_addr;
  csr_pkg::csr_data_t hart_wdata;
  logic               hart_ack;
  csr_pkg::csr_data_t hart_rdata;
  logic               dbg_req;
  csr_pkg::csr_op_t   dbg_op;
  csr_pkg::csr_addr_t dbg_addr;
  csr_pkg::csr_data_t dbg_wdata;
  logic               dbg_ack;
  csr_pkg::csr_data_t dbg_rdata;
  csr_pkg::btn_t      btn;
  csr_pkg::led_t      led;
  logic               tx;

  int                   errors;
  int                   timeouts;
  int                   rx_count;
  logic [31:0]          rng_state;
  csr_pkg::csr_data_t   led_model;
  logic                 hart_ack_d;
  logic                 dbg_ack_d;
  // expected old values per port and the order in which acks were seen
  csr_pkg::csr_data_t   exp_hart_q[$];
  csr_pkg::csr_data_t   exp_dbg_q[$];
  logic                 served_q[$];
  uart_pkg::uart_byte_t exp_byte_q[$];
  event                 run_done;

  csr_subsys_top #(
    .FifoDepth  (FifoDepth),
    .ClksPerBit (ClksPerBit)
  ) DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .hart_req   (hart_req),
    .hart_op    (hart_op),
    .hart_addr  (hart_addr),
    .hart_wdata (hart_wdata),
    .hart_ack   (hart_ack),
    .hart_rdata (hart_rdata),
    .dbg_req    (dbg_req),
    .dbg_op     (dbg_op),
    .dbg_addr   (dbg_addr),
    .dbg_wdata  (dbg_wdata),
    .dbg_ack    (dbg_ack),
    .dbg_rdata  (dbg_rdata),
    .btn        (btn),
    .led        (led),
    .tx         (tx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // LED register model that returns the value an access sees before it lands
  function automatic csr_pkg::csr_data_t ref_csr(input csr_pkg::csr_op_t op,
                                                 input csr_pkg::csr_data_t wdata);
    csr_pkg::csr_data_t old_val;
    old_val = led_model;
    case (op)
      csr_pkg::csr_write: led_model = wdata;
      csr_pkg::csr_set:   led_model = led_model | wdata;
      csr_pkg::csr_clear: led_model = led_model & ~wdata;
      default:            led_model = led_model;
    endcase
    // only LedWidth pins exist
    led_model = led_model & LedMask;
    return old_val;
  endfunction

  function automatic csr_pkg::csr_data_t status_word(input int count);
    csr_pkg::csr_data_t word;
    word      = '0;
    word[7:0] = count[7:0];
    word[8]   = (count == FifoDepth);
    word[9]   = (count == 0);
    return word;
  endfunction

  task automatic flag_timeout(input string what);
    timeouts++;
    $display("timeout: %s", what);
    -> run_done;
  endtask

  task automatic wait_ack(input logic port_dbg, input logic level);
    int cycles;
    cycles = 0;
    while (((port_dbg ? dbg_ack : hart_ack) != level) && cycles < AckTimeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if ((port_dbg ? dbg_ack : hart_ack) != level) begin
      flag_timeout(port_dbg ? "dbg handshake stalled" : "hart handshake stalled");
    end
  endtask

  task automatic hart_access(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                             input csr_pkg::csr_data_t wdata,
                             input csr_pkg::csr_data_t exp_rdata);
    exp_hart_q.push_back(exp_rdata);
    @(posedge clk);
    #1;
    hart_op    = op;
    hart_addr  = addr;
    hart_wdata = wdata;
    hart_req   = 1'b1;
    wait_ack(1'b0, 1'b1);
    hart_req = 1'b0;
    wait_ack(1'b0, 1'b0);
  endtask

  task automatic dbg_access(input csr_pkg::csr_op_t op, input csr_pkg::csr_addr_t addr,
                            input csr_pkg::csr_data_t wdata,
                            input csr_pkg::csr_data_t exp_rdata);
    exp_dbg_q.push_back(exp_rdata);
    @(posedge clk);
    #1;
    dbg_op    = op;
    dbg_addr  = addr;
    dbg_wdata = wdata;
    dbg_req   = 1'b1;
    wait_ack(1'b1, 1'b1);
    dbg_req = 1'b0;
    wait_ack(1'b1, 1'b0);
  endtask

  task automatic check_rdata(input logic port_dbg, input csr_pkg::csr_data_t rdata);
    csr_pkg::csr_data_t exp_val;
    served_q.push_back(port_dbg);
    if (port_dbg ? (exp_dbg_q.size() == 0) : (exp_hart_q.size() == 0)) begin
      errors++;
      $display("ack seen on the %s port with no access pending", port_dbg ? "dbg" : "hart");
    end else begin
      if (port_dbg) begin
        exp_val = exp_dbg_q.pop_front();
      end else begin
        exp_val = exp_hart_q.pop_front();
      end
      assert (rdata == exp_val) else begin
        errors++;
        $display("Error: %s_rdata = %h, expected %h", port_dbg ? "dbg" : "hart", rdata, exp_val);
      end
    end
  endtask

  // compare read data once per ack in mid-cycle
  always @(negedge clk) begin
    if (hart_ack && !hart_ack_d) begin
      check_rdata(1'b0, hart_rdata);
    end
    if (dbg_ack && !dbg_ack_d) begin
      check_rdata(1'b1, dbg_rdata);
    end
    hart_ack_d = hart_ack;
    dbg_ack_d  = dbg_ack;
  end

  // UART monitor samples each bit in its middle
  initial begin : uart_monitor
    uart_pkg::uart_byte_t got;
    uart_pkg::uart_byte_t exp_byte;
    forever begin
      @(posedge clk);
      #2;
      if (arst_n && tx === 1'b0) begin
        repeat (ClksPerBit / 2) @(posedge clk);
        #2;
        assert (tx === 1'b0) else begin
          errors++;
          $display("start bit on tx ended before its middle");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (ClksPerBit) @(posedge clk);
          #2;
          got[i] = tx;
        end
        repeat (ClksPerBit) @(posedge clk);
        #2;
        assert (tx === 1'b1) else begin
          errors++;
          $display("stop bit on tx was low for byte %h", got);
        end
        if (exp_byte_q.size() == 0) begin
          errors++;
          $display("unexpected byte %h received on tx", got);
        end else begin
          exp_byte = exp_byte_q.pop_front();
          assert (got == exp_byte) else begin
            errors++;
            $display("Error: tx byte = %h, expected %h", got, exp_byte);
          end
        end
        rx_count++;
      end
    end
  end

  task automatic wait_uart_drain(input int limit);
    int cycles;
    cycles = 0;
    while (exp_byte_q.size() != 0 && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_byte_q.size() != 0) begin
      flag_timeout("UART monitor did not receive all expected bytes");
    end
  endtask

  // both ports request on the same edge and the order follows the last port served
  task automatic race_round(input csr_pkg::csr_op_t op, input csr_pkg::csr_data_t hart_wd,
                            input csr_pkg::csr_data_t dbg_wd);
    logic               dbg_first;
    int                 base;
    csr_pkg::csr_data_t hart_exp;
    csr_pkg::csr_data_t dbg_exp;
    dbg_first = !served_q[$];
    base      = served_q.size();
    if (dbg_first) begin
      dbg_exp  = ref_csr(op, dbg_wd);
      hart_exp = ref_csr(op, hart_wd);
    end else begin
      hart_exp = ref_csr(op, hart_wd);
      dbg_exp  = ref_csr(op, dbg_wd);
    end
    fork
      hart_access(op, csr_pkg::LedAddr, hart_wd, hart_exp);
      dbg_access(op, csr_pkg::LedAddr, dbg_wd, dbg_exp);
    join
    assert (served_q.size() == base + 2 && served_q[base] == dbg_first) else begin
      errors++;
      $display("simultaneous requests were not served in round-robin order");
    end
  endtask

  initial begin : main
    logic [31:0]          r;
    csr_pkg::csr_op_t     op;
    csr_pkg::csr_data_t   exp_old;
    int                   rx_before;
    errors     = 0;
    timeouts   = 0;
    rx_count   = 0;
    rng_state  = 32'h72f7_84d7;
    led_model  = '0;
    hart_ack_d = 1'b0;
    dbg_ack_d  = 1'b0;
    arst_n     = 1'b0;
    hart_req   = 1'b0;
    hart_op    = csr_pkg::csr_read;
    hart_addr  = '0;
    hart_wdata = '0;
    dbg_req    = 1'b0;
    dbg_op     = csr_pkg::csr_read;
    dbg_addr   = '0;
    dbg_wdata  = '0;
    btn        = '0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // reset values
    assert (hart_ack == 1'b0) else begin
      errors++;
      $display("Error: hart_ack = %h, expected 0", hart_ack);
    end
    assert (dbg_ack == 1'b0) else begin
      errors++;
      $display("Error: dbg_ack = %h, expected 0", dbg_ack);
    end
    assert (tx == 1'b1) else begin
      errors++;
      $display("Error: tx = %h, expected 1", tx);
    end
    assert (led == '0) else begin
      errors++;
      $display("Error: led = %h, expected 0", led);
    end
    hart_access(csr_pkg::csr_read, csr_pkg::TxStatAddr, '0, status_word(0));

    // random LED operations over both ports
    for (int i = 0; i < 40; i++) begin
      r       = next_random();
      op      = csr_pkg::csr_op_t'(r[1:0]);
      exp_old = ref_csr(op, next_random());
      if (r[2]) begin
        dbg_access(op, csr_pkg::LedAddr, rng_state, exp_old);
      end else begin
        hart_access(op, csr_pkg::LedAddr, rng_state, exp_old);
      end
      assert (led == led_model[csr_pkg::LedWidth-1:0]) else begin
        errors++;
        $display("Error: led = %h, expected %h", led, led_model[csr_pkg::LedWidth-1:0]);
      end
    end

    // two-flop button synchronizer needs a few cycles
    for (int i = 0; i < 4; i++) begin
      r = next_random();
      @(posedge clk);
      #1;
      btn = r[csr_pkg::BtnWidth-1:0];
      repeat (4) @(posedge clk);
      hart_access(csr_pkg::csr_read, csr_pkg::BtnAddr, '0, csr_pkg::csr_data_t'(btn));
      dbg_access(csr_pkg::csr_write, csr_pkg::BtnAddr, next_random(), csr_pkg::csr_data_t'(btn));
      hart_access(csr_pkg::csr_read, csr_pkg::BtnAddr, '0, csr_pkg::csr_data_t'(btn));
    end

    // single bytes with idle line between frames
    for (int i = 0; i < 3; i++) begin
      r = next_random();
      exp_byte_q.push_back(r[7:0]);
      hart_access(csr_pkg::csr_write, csr_pkg::TxDataAddr, r, '0);
      wait_uart_drain(2 * FrameCycles);
      repeat (FrameCycles) @(posedge clk);
    end

    // overflow keeps one byte in flight plus FifoDepth held and drops the rest
    rx_before = rx_count;
    for (int i = 0; i < 7; i++) begin
      r = next_random();
      if (i < FifoDepth + 1) begin
        exp_byte_q.push_back(r[7:0]);
      end
      hart_access(csr_pkg::csr_write, csr_pkg::TxDataAddr, r, '0);
    end
    hart_access(csr_pkg::csr_read, csr_pkg::TxStatAddr, '0, status_word(FifoDepth));
    wait_uart_drain(7 * FrameCycles);
    repeat (2 * FrameCycles) @(posedge clk);
    assert (rx_count == rx_before + FifoDepth + 1) else begin
      errors++;
      $display("UART sent %0d bytes after overflow instead of %0d",
               rx_count - rx_before, FifoDepth + 1);
    end

    // simultaneous requests
    for (int i = 0; i < 4; i++) begin
      // a lone access hands the next tie to the other port
      exp_old = ref_csr(csr_pkg::csr_read, '0);
      if (i[0]) begin
        dbg_access(csr_pkg::csr_read, csr_pkg::LedAddr, '0, exp_old);
      end else begin
        hart_access(csr_pkg::csr_read, csr_pkg::LedAddr, '0, exp_old);
      end
      r = next_random();
      race_round(csr_pkg::csr_write, r, next_random());
      race_round(csr_pkg::csr_read, '0, '0);
    end

    -> run_done;
  end

  initial begin : run_end
    @(run_done);
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
common/csr_pkg.sv
common/uart_pkg.sv
rtl/csr_arbiter.sv
rtl/csr_io.sv
uart/uart_tx_fifo.sv
uart/uart_tx.sv
rtl/csr_subsys_top.sv
tests/tb_csr_subsys.sv

// File: run.sh
#!/bin/sh
# build the CSR subsystem testbench with Verilator, run it, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_csr_subsys -f flist.f \
  && ./obj_dir/Vtb_csr_subsys > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
